// File: bench/tb_i2c_slave.sv
// controller model runs about 80 clocks per SCL bit; read data is checked against the responder memory
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_slave;

    localparam logic [6:0] ADDR       = 7'h55;
    localparam int         WAIT_LIMIT = 2000;   // clocks allowed for any single wait

    logic       clk = 1'b0;
    logic       rst_n;
    logic       scl_low;
    logic       sda_low;
    logic       slow_rsp;
    logic       bus_ack = 1'b0;
    logic [7:0] bus_rdata = 8'h00;
    wire        scl_line;
    wire        sda_line;
    wire        scl_oe;
    wire        sda_oe;
    wire        pec_error;
    wire        start_evt;
    wire        stop_evt;
    wire        bus_req;
    wire        bus_we;
    wire  [7:0] bus_addr;
    wire  [7:0] bus_wdata;

    logic [7:0] mem [256];
    logic       mem_ready = 1'b0;
    logic [1:0] rsp_state = 2'd0;
    int         rsp_delay = 0;
    int         req_count = 0;
    int         pec_pulses = 0;
    int         start_pulses = 0;
    int         stop_pulses = 0;
    int         test_errs = 0;
    int         tests_run = 0;
    int         tests_failed = 0;
    int         total_errs = 0;

    // open-drain lines with pull-ups
    assign scl_line = ~(scl_low | scl_oe);
    assign sda_line = ~(sda_low | sda_oe);

    always #2 clk = ~clk;

    i2c_slave_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_scl       (scl_line),
        .i_sda       (sda_line),
        .o_scl_oe    (scl_oe),
        .o_sda_oe    (sda_oe),
        .o_pec_error (pec_error),
        .o_start     (start_evt),
        .o_stop      (stop_evt),
        .o_bus_req   (bus_req),
        .o_bus_we    (bus_we),
        .o_bus_addr  (bus_addr),
        .o_bus_wdata (bus_wdata),
        .i_bus_ack   (bus_ack),
        .i_bus_rdata (bus_rdata)
    );

    // register bus responder, four-phase
    always @(posedge clk) begin
        #1;
        if (!mem_ready) begin
            for (int i = 0; i < 256; i++) begin
                mem[8'(i)] = 8'(i * 37 + 11);
            end
            mem_ready = 1'b1;
        end
        case (rsp_state)
            2'd0: begin
                if (bus_req && !bus_ack) begin
                    rsp_delay = slow_rsp ? 20 : $urandom % 21;
                    req_count++;
                    rsp_state = 2'd1;
                end
            end
            2'd1: begin
                if (rsp_delay == 0) begin
                    if (bus_we) begin
                        mem[bus_addr] = bus_wdata;
                    end
                    bus_rdata = mem[bus_addr];
                    bus_ack   = 1'b1;
                    rsp_state = 2'd2;
                end else begin
                    rsp_delay--;
                end
            end
            default: begin
                if (!bus_req) begin
                    bus_ack   = 1'b0;
                    rsp_state = 2'd0;
                end
            end
        endcase
    end

    always @(posedge clk) begin
        #1;
        if (pec_error) begin
            pec_pulses++;
        end
        if (start_evt) begin
            start_pulses++;
        end
        if (stop_evt) begin
            stop_pulses++;
        end
    end

    // msb first, one data bit per step
    function automatic logic [7:0] crc8_step(input logic [7:0] crc, input logic [7:0] data);
        logic [7:0] c;
        logic [7:0] d;
        logic       fb;
        c = crc;
        d = data;
        for (int i = 0; i < 8; i++) begin
            fb = c[7] ^ d[7];
            c  = {c[6:0], 1'b0};
            d  = d << 1;
            if (fb) begin
                c = c ^ 8'h07;
            end
        end
        return c;
    endfunction

    task automatic abort_timeout(input string what);
        $display("timeout: %s did not happen within %0d clocks", what, WAIT_LIMIT);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic wait_scl_high();
        int waited = 0;
        while (!scl_line && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!scl_line) begin
            abort_timeout("SCL release by the DUT");
        end
    endtask

    task automatic wait_bus_idle();
        int waited = 0;
        while ((bus_req || bus_ack || rsp_state != 2'd0) && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (bus_req || bus_ack) begin
            abort_timeout("register bus idle");
        end
    endtask

    task automatic expect_eq(input string name, input logic [7:0] exp, input logic [7:0] act);
        assert (exp === act) else begin
            $display("ERROR %s: expected %02h, actual %02h", name, exp, act);
            test_errs++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: FAILED with %0d errors", name, test_errs);
            tests_failed++;
        end
        total_errs += test_errs;
        test_errs = 0;
    endtask

    task automatic send_start();
        sda_low = 1'b1;
        wait_cycles(40);
        scl_low = 1'b1;
        wait_cycles(10);
    endtask

    task automatic send_restart();
        sda_low = 1'b0;
        wait_cycles(30);
        scl_low = 1'b0;
        wait_scl_high();
        wait_cycles(40);
        sda_low = 1'b1;
        wait_cycles(40);
        scl_low = 1'b1;
        wait_cycles(10);
    endtask

    task automatic send_stop();
        sda_low = 1'b1;
        wait_cycles(30);
        scl_low = 1'b0;
        wait_scl_high();
        wait_cycles(40);
        sda_low = 1'b0;
        wait_cycles(40);
    endtask

    // enters and leaves with SCL low, sda set 10 clocks into the low phase
    task automatic clock_bit(input logic drive_val, output logic sampled);
        sda_low = ~drive_val;
        wait_cycles(30);
        scl_low = 1'b0;
        wait_scl_high();
        wait_cycles(20);
        sampled = sda_line;
        wait_cycles(20);
        scl_low = 1'b1;
        wait_cycles(10);
    endtask

    task automatic write_byte(input logic [7:0] b, output logic ack);
        logic [7:0] sh;
        logic       bit_v;
        sh = b;
        for (int i = 0; i < 8; i++) begin
            clock_bit(sh[7], bit_v);
            sh = sh << 1;
        end
        clock_bit(1'b1, ack);   // low means ACK
    endtask

    task automatic read_byte(input logic nack, output logic [7:0] b);
        logic bit_v;
        b = 8'h00;
        for (int i = 0; i < 8; i++) begin
            clock_bit(1'b1, bit_v);
            b = {b[6:0], bit_v};
        end
        clock_bit(nack, bit_v);
    endtask

    task automatic write_transfer(input string name, input logic [7:0] ptr,
                                  input logic [23:0] data, input logic corrupt);
        logic [7:0] pec;
        logic [7:0] byte_v;
        logic       ack;
        int         starts;
        int         stops;
        pec = crc8_step(8'h00, {ADDR, 1'b0});
        pec = crc8_step(pec, ptr);
        for (int i = 0; i < 3; i++) begin
            pec = crc8_step(pec, 8'(data >> (16 - 8 * i)));
        end
        if (corrupt) begin
            pec = pec ^ 8'h01;
        end
        starts = start_pulses;
        stops  = stop_pulses;
        send_start();
        write_byte({ADDR, 1'b0}, ack);
        expect_eq({name, " address ack"}, 8'h00, 8'(ack));
        write_byte(ptr, ack);
        expect_eq({name, " pointer ack"}, 8'h00, 8'(ack));
        for (int i = 0; i < 3; i++) begin
            byte_v = 8'(data >> (16 - 8 * i));
            write_byte(byte_v, ack);
            expect_eq($sformatf("%s data %0d ack", name, i), 8'h00, 8'(ack));
        end
        write_byte(pec, ack);
        expect_eq({name, " pec ack"}, 8'h00, 8'(ack));
        send_stop();
        wait_bus_idle();
        for (int i = 0; i < 3; i++) begin
            expect_eq($sformatf("%s mem %0d", name, i), 8'(data >> (16 - 8 * i)),
                      mem[8'(ptr + i)]);
        end
        expect_eq({name, " mem pec"}, pec, mem[ptr + 8'd3]);
        expect_eq({name, " start pulses"}, 8'h01, 8'(start_pulses - starts));
        expect_eq({name, " stop pulses"}, 8'h01, 8'(stop_pulses - stops));
    endtask

    task automatic read_transfer(input string name, input logic [7:0] ptr);
        logic [7:0] expected [4];
        logic [7:0] got;
        logic       ack;
        int         starts;
        int         stops;
        for (int i = 0; i < 4; i++) begin
            expected[i] = mem[8'(ptr + i)];     // memory as it was before the read
        end
        starts = start_pulses;
        stops  = stop_pulses;
        send_start();
        write_byte({ADDR, 1'b0}, ack);
        expect_eq({name, " address ack"}, 8'h00, 8'(ack));
        write_byte(ptr, ack);
        expect_eq({name, " pointer ack"}, 8'h00, 8'(ack));
        send_restart();
        write_byte({ADDR, 1'b1}, ack);
        expect_eq({name, " read address ack"}, 8'h00, 8'(ack));
        for (int i = 0; i < 4; i++) begin
            read_byte(i == 3, got);   // NACK ends the read
            expect_eq($sformatf("%s byte %0d", name, i), expected[i], got);
        end
        send_stop();
        wait_bus_idle();
        expect_eq({name, " start pulses"}, 8'h02, 8'(start_pulses - starts));
        expect_eq({name, " stop pulses"}, 8'h01, 8'(stop_pulses - stops));
    endtask

    initial begin
        int unsigned seed_val;
        int          base;
        int          starts;
        int          stops;
        logic        ack;
        seed_val = $urandom(32'hb4f7);
        rst_n    = 1'b0;
        scl_low  = 1'b0;
        sda_low  = 1'b0;
        slow_rsp = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        wait_cycles(10);

        expect_eq("reset bus_req", 8'h00, 8'(bus_req));
        expect_eq("reset scl_oe", 8'h00, 8'(scl_oe));
        expect_eq("reset sda_oe", 8'h00, 8'(sda_oe));
        expect_eq("reset pec_error", 8'h00, 8'(pec_error));
        expect_eq("reset start", 8'h00, 8'(start_evt));
        expect_eq("reset stop", 8'h00, 8'(stop_evt));
        end_test("reset_state");

        base = pec_pulses;
        write_transfer("write_pec", 8'h10, 24'($urandom), 1'b0);
        expect_eq("write_pec error pulses", 8'h00, 8'(pec_pulses - base));
        end_test("write_pec");

        base = pec_pulses;
        write_transfer("bad_pec", 8'h20, 24'($urandom), 1'b1);
        expect_eq("bad_pec error pulses", 8'h01, 8'(pec_pulses - base));
        end_test("bad_pec");

        base   = req_count;
        starts = start_pulses;
        stops  = stop_pulses;
        send_start();
        write_byte({7'h23, 1'b0}, ack);
        expect_eq("addr_mismatch ack", 8'h01, 8'(ack));   // SDA left high
        send_stop();
        expect_eq("addr_mismatch bus requests", 8'h00, 8'(req_count - base));
        expect_eq("addr_mismatch start pulses", 8'h01, 8'(start_pulses - starts));
        expect_eq("addr_mismatch stop pulses", 8'h01, 8'(stop_pulses - stops));
        end_test("addr_mismatch");

        read_transfer("read_back", 8'h80);
        end_test("read_back");

        slow_rsp = 1'b1;
        base = pec_pulses;
        write_transfer("slow_write", 8'hc0, 24'($urandom), 1'b0);
        expect_eq("slow_write error pulses", 8'h00, 8'(pec_pulses - base));
        read_transfer("slow_read", 8'hc0);
        slow_rsp = 1'b0;
        end_test("slow_responder");

        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, total_errs);
        if (total_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: include/i2c_slave_defs.svh
// build-time constants only; the target answers a single fixed 7-bit address
`ifndef I2C_SLAVE_DEFS_SVH
`define I2C_SLAVE_DEFS_SVH

// own address, no 10-bit or general call support
`define I2C_TARGET_ADDR 7'h55

`define I2C_SPIKE_LEN 2         // clocks a new line level must hold
`define I2C_BYTE_W 8

// SMBus PEC, x^8 + x^2 + x + 1
`define PEC_POLY 8'h07

`endif

// File: logic/i2c_line_filter.sv
// lines read as idle high out of reset; events lag the pins by about 3 + I2C_SPIKE_LEN clocks
`timescale 1ns/1ps
`default_nettype none
`include "i2c_slave_defs.svh"

module i2c_line_filter (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  i_scl,
    input  wire  i_sda,
    output logic o_scl,
    output logic o_sda,
    output logic o_scl_rise,
    output logic o_scl_fall,
    output logic o_start,
    output logic o_stop
);

    localparam int CNT_W = $clog2(`I2C_SPIKE_LEN + 1);

    // bit 0 is scl, bit 1 is sda
    logic [1:0]       meta;
    logic [1:0]       sync;
    logic [1:0]       level;    // accepted level
    logic [1:0]       level_q;
    logic [CNT_W-1:0] stable_cnt [2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            meta <= 2'b11;
            sync <= 2'b11;
        end else begin
            meta <= {i_sda, i_scl};
            sync <= meta;
        end
    end

    // a level change is taken only once it has held for the spike length
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            level      <= 2'b11;
            stable_cnt <= '{default: '0};
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (sync[i] == level[i]) begin
                    stable_cnt[i] <= '0;        // spike over, start again
                end else if (stable_cnt[i] == CNT_W'(`I2C_SPIKE_LEN - 1)) begin
                    level[i]      <= sync[i];
                    stable_cnt[i] <= '0;
                end else begin
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            level_q    <= 2'b11;
            o_scl_rise <= 1'b0;
            o_scl_fall <= 1'b0;
            o_start    <= 1'b0;
            o_stop     <= 1'b0;
        end else begin
            level_q    <= level;
            o_scl_rise <= level[0] & ~level_q[0];
            o_scl_fall <= ~level[0] & level_q[0];
            o_start    <= level[0] & level_q[0] & ~level[1] & level_q[1];  // sda falls, scl high
            o_stop     <= level[0] & level_q[0] & level[1] & ~level_q[1];
        end
    end

    // delayed copy lines up with the event pulses
    assign o_scl = level_q[0];
    assign o_sda = level_q[1];

endmodule

`default_nettype wire

// File: logic/i2c_slave_pkg.sv
// encodings shared by the target FSM and the register bus bridge
`default_nettype none

package i2c_slave_pkg;

    typedef enum logic [2:0] {
        st_idle,
        st_addr,
        st_addr_ack,
        st_wr_byte,
        st_wr_ack,
        st_ptr_byte,
        st_rd_byte,
        st_rd_ack_wait
    } target_state_e;

    typedef enum logic {
        op_write,
        op_read
    } bus_op_e;

endpackage

`default_nettype wire

// File: logic/i2c_slave_top.sv
// oe outputs pull the pin low when high; the pads and pull-ups live outside this block
`timescale 1ns/1ps
`default_nettype none
`include "i2c_slave_defs.svh"

module i2c_slave_top (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   i_scl,
    input  wire                   i_sda,
    output wire                   o_scl_oe,
    output wire                   o_sda_oe,
    output wire                   o_pec_error,
    output wire                   o_start,
    output wire                   o_stop,
    output wire                   o_bus_req,
    output wire                   o_bus_we,
    output wire [`I2C_BYTE_W-1:0] o_bus_addr,
    output wire [`I2C_BYTE_W-1:0] o_bus_wdata,
    input  wire                   i_bus_ack,
    input  wire [`I2C_BYTE_W-1:0] i_bus_rdata
);

    logic                    scl_f;
    logic                    sda_f;
    logic                    scl_rise;
    logic                    scl_fall;
    logic                    byte_strobe;
    logic [`I2C_BYTE_W-1:0]  byte_val;
    logic                    op_go;
    i2c_slave_pkg::bus_op_e  op;
    logic [`I2C_BYTE_W-1:0]  ptr;
    logic [`I2C_BYTE_W-1:0]  wdata;
    logic                    busy;
    logic [`I2C_BYTE_W-1:0]  rd_data;
    logic                    rd_valid;

    i2c_line_filter u_filter (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_scl      (i_scl),
        .i_sda      (i_sda),
        .o_scl      (scl_f),
        .o_sda      (sda_f),
        .o_scl_rise (scl_rise),
        .o_scl_fall (scl_fall),
        .o_start    (o_start),
        .o_stop     (o_stop)
    );

    i2c_target_fsm u_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_scl         (scl_f),
        .i_sda         (sda_f),
        .i_scl_rise    (scl_rise),
        .i_scl_fall    (scl_fall),
        .i_start       (o_start),
        .i_stop        (o_stop),
        .i_bridge_busy (busy),
        .i_rd_data     (rd_data),
        .i_rd_valid    (rd_valid),
        .o_sda_oe      (o_sda_oe),
        .o_scl_oe      (o_scl_oe),
        .o_byte_strobe (byte_strobe),
        .o_byte        (byte_val),
        .o_op_go       (op_go),
        .o_op          (op),
        .o_ptr         (ptr),
        .o_wdata       (wdata)
    );

    pec_crc8 u_pec (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_byte_strobe (byte_strobe),
        .i_byte        (byte_val),
        .i_stop        (o_stop),
        .o_pec_error   (o_pec_error)
    );

    reg_bus_bridge u_bridge (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_op_go     (op_go),
        .i_op        (op),
        .i_ptr       (ptr),
        .i_wdata     (wdata),
        .i_bus_ack   (i_bus_ack),
        .i_bus_rdata (i_bus_rdata),
        .o_busy      (busy),
        .o_rd_data   (rd_data),
        .o_rd_valid  (rd_valid),
        .o_bus_req   (o_bus_req),
        .o_bus_we    (o_bus_we),
        .o_bus_addr  (o_bus_addr),
        .o_bus_wdata (o_bus_wdata)
    );

endmodule

`default_nettype wire

// File: logic/i2c_target_fsm.sv
// 7-bit target only; the first written byte is the pointer, a NACK or STOP ends a read
`timescale 1ns/1ps
`default_nettype none
`include "i2c_slave_defs.svh"

module i2c_target_fsm
    import i2c_slave_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   i_scl,
    input  wire                   i_sda,
    input  wire                   i_scl_rise,
    input  wire                   i_scl_fall,
    input  wire                   i_start,
    input  wire                   i_stop,
    input  wire                   i_bridge_busy,
    input  wire [`I2C_BYTE_W-1:0] i_rd_data,
    input  wire                   i_rd_valid,
    output logic                  o_sda_oe,
    output logic                  o_scl_oe,
    output logic                  o_byte_strobe,
    output logic [`I2C_BYTE_W-1:0] o_byte,
    output logic                  o_op_go,
    output bus_op_e               o_op,
    output logic [`I2C_BYTE_W-1:0] o_ptr,
    output logic [`I2C_BYTE_W-1:0] o_wdata
);

    target_state_e          state;
    logic [`I2C_BYTE_W-1:0] shreg;
    logic [3:0]             bit_cnt;
    logic                   rd_xfer;    // matched address had R set
    logic                   rd_loaded;
    logic [`I2C_BYTE_W-1:0] rx_byte;
    logic                   rx_last;
    logic                   addr_hit;

    assign rx_byte  = {shreg[`I2C_BYTE_W-2:0], i_sda};
    assign rx_last  = i_scl_rise && (bit_cnt == 4'd7);
    assign addr_hit = (rx_byte[`I2C_BYTE_W-1:1] == `I2C_TARGET_ADDR);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= st_idle;
            shreg         <= '0;
            bit_cnt       <= '0;
            rd_xfer       <= 1'b0;
            rd_loaded     <= 1'b0;
            o_sda_oe      <= 1'b0;
            o_scl_oe      <= 1'b0;
            o_byte_strobe <= 1'b0;
            o_byte        <= '0;
            o_op_go       <= 1'b0;
            o_op          <= op_write;
            o_ptr         <= '0;
            o_wdata       <= '0;
        end else begin
            o_byte_strobe <= 1'b0;
            o_op_go       <= 1'b0;
            if (o_op_go) begin
                o_ptr <= o_ptr + 1'b1;  // bridge already latched the old value
            end
            if (i_rd_valid && rd_xfer && state != st_idle) begin
                shreg     <= i_rd_data;
                rd_loaded <= 1'b1;
            end

            if (i_stop) begin
                state     <= st_idle;
                o_sda_oe  <= 1'b0;
                o_scl_oe  <= 1'b0;
                rd_xfer   <= 1'b0;
                rd_loaded <= 1'b0;
            end else if (i_start) begin   // also repeated START
                state     <= st_addr;
                bit_cnt   <= '0;
                o_sda_oe  <= 1'b0;
                o_scl_oe  <= 1'b0;
                rd_xfer   <= 1'b0;
                rd_loaded <= 1'b0;
            end else begin
                if (i_scl_rise && state inside {st_addr, st_ptr_byte, st_wr_byte}) begin
                    shreg   <= rx_byte;
                    bit_cnt <= bit_cnt + 1'b1;
                end
                case (state)
                    st_addr: begin
                        if (rx_last && addr_hit) begin
                            state         <= st_addr_ack;
                            rd_xfer       <= rx_byte[0];
                            o_byte_strobe <= 1'b1;
                            o_byte        <= {rx_byte[`I2C_BYTE_W-1:1], 1'b0};  // R/W as 0
                            if (rx_byte[0]) begin
                                o_op_go <= 1'b1;  // prefetch first read byte
                                o_op    <= op_read;
                            end
                        end else if (rx_last) begin
                            state <= st_idle;   // not ours, no ACK
                        end
                    end
                    st_ptr_byte: begin
                        if (rx_last) begin
                            state         <= st_wr_ack;
                            o_ptr         <= rx_byte;
                            o_byte_strobe <= 1'b1;
                            o_byte        <= rx_byte;
                        end
                    end
                    st_wr_byte: begin
                        if (o_scl_oe && !i_bridge_busy) begin
                            o_scl_oe <= 1'b0;
                        end
                        if (rx_last) begin
                            state         <= st_wr_ack;
                            o_byte_strobe <= 1'b1;
                            o_byte        <= rx_byte;
                            o_wdata       <= rx_byte;
                            o_op          <= op_write;
                            o_op_go       <= 1'b1;
                        end
                    end
                    // first fall starts the ACK bit, second one ends it
                    st_addr_ack, st_wr_ack: begin
                        if (i_scl_fall && !o_sda_oe) begin
                            o_sda_oe <= 1'b1;
                        end else if (i_scl_fall) begin
                            o_sda_oe <= 1'b0;
                            bit_cnt  <= '0;
                            if (state == st_wr_ack) begin
                                state    <= st_wr_byte;
                                o_scl_oe <= i_bridge_busy;  // stretch until write lands
                            end else if (rd_xfer) begin
                                state    <= st_rd_byte;
                                o_scl_oe <= 1'b1;
                            end else begin
                                state <= st_ptr_byte;
                            end
                        end
                    end
                    st_rd_byte: begin
                        if (o_scl_oe) begin
                            if (bit_cnt != 4'd0) begin
                                o_scl_oe <= 1'b0;   // msb settled, release SCL
                            end else if (rd_loaded && !i_scl) begin
                                o_sda_oe  <= ~shreg[`I2C_BYTE_W-1];
                                bit_cnt   <= 4'd1;
                                rd_loaded <= 1'b0;
                            end
                        end else if (i_scl_fall && bit_cnt == 4'd8) begin
                            o_sda_oe <= 1'b0;       // controller owns the ACK bit
                            state    <= st_rd_ack_wait;
                        end else if (i_scl_fall) begin
                            o_sda_oe <= ~shreg[`I2C_BYTE_W-2];
                            shreg    <= shreg << 1;
                            bit_cnt  <= bit_cnt + 1'b1;
                        end
                    end
                    st_rd_ack_wait: begin
                        if (i_scl_rise && i_sda) begin
                            state <= st_idle;
                        end else if (i_scl_rise) begin
                            o_op_go <= 1'b1;
                            o_op    <= op_read;
                        end else if (i_scl_fall) begin
                            state    <= st_rd_byte;
                            o_scl_oe <= 1'b1;
                            bit_cnt  <= '0;
                        end
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/pec_crc8.sv
// remainder runs across repeated STARTs and is only cleared by STOP
`timescale 1ns/1ps
`default_nettype none
`include "i2c_slave_defs.svh"

module pec_crc8 (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   i_byte_strobe,
    input  wire [`I2C_BYTE_W-1:0] i_byte,
    input  wire                   i_stop,
    output logic                  o_pec_error
);

    logic [`I2C_BYTE_W-1:0] crc;

    // msb first, whole byte per call
    function automatic logic [`I2C_BYTE_W-1:0] crc_byte(
        input logic [`I2C_BYTE_W-1:0] crc_in,
        input logic [`I2C_BYTE_W-1:0] data
    );
        logic [`I2C_BYTE_W-1:0] c;
        c = crc_in ^ data;
        for (int i = 0; i < `I2C_BYTE_W; i++) begin
            c = c[`I2C_BYTE_W-1] ? ((c << 1) ^ `PEC_POLY) : (c << 1);
        end
        return c;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc         <= '0;
            o_pec_error <= 1'b0;
        end else if (i_stop) begin
            o_pec_error <= |crc;    // good PEC leaves zero
            crc         <= '0;
        end else begin
            o_pec_error <= 1'b0;
            if (i_byte_strobe) begin
                crc <= crc_byte(crc, i_byte);
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/reg_bus_bridge.sv
// one access at a time; an i_op_go that arrives while busy is dropped
`timescale 1ns/1ps
`default_nettype none
`include "i2c_slave_defs.svh"

module reg_bus_bridge
    import i2c_slave_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    i_op_go,
    input  wire bus_op_e           i_op,
    input  wire [`I2C_BYTE_W-1:0]  i_ptr,
    input  wire [`I2C_BYTE_W-1:0]  i_wdata,
    input  wire                    i_bus_ack,
    input  wire [`I2C_BYTE_W-1:0]  i_bus_rdata,
    output logic                   o_busy,
    output logic [`I2C_BYTE_W-1:0] o_rd_data,
    output logic                   o_rd_valid,
    output logic                   o_bus_req,
    output logic                   o_bus_we,
    output logic [`I2C_BYTE_W-1:0] o_bus_addr,
    output logic [`I2C_BYTE_W-1:0] o_bus_wdata
);

    bus_op_e op_q;

    assign o_bus_we = (op_q == op_write);

    // four-phase: req up, ack up, req down, ack down
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_busy     <= 1'b0;
            o_bus_req  <= 1'b0;
            o_rd_valid <= 1'b0;
            op_q       <= op_write;
        end else begin
            o_rd_valid <= 1'b0;
            if (!o_busy) begin
                if (i_op_go) begin
                    o_busy    <= 1'b1;
                    o_bus_req <= 1'b1;
                    op_q      <= i_op;
                end
            end else if (o_bus_req) begin
                if (i_bus_ack) begin
                    o_bus_req <= 1'b0;
                end
            end else if (!i_bus_ack) begin
                o_busy     <= 1'b0;     // responder back to idle
                o_rd_valid <= (op_q == op_read);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_op_go && !o_busy) begin
            o_bus_addr  <= i_ptr;
            o_bus_wdata <= i_wdata;
        end
        if (o_bus_req && i_bus_ack && op_q == op_read) begin
            o_rd_data <= i_bus_rdata;   // only valid while ack is high
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_i2c_slave -f src.f || exit 1
out=$(./obj_dir/Vtb_i2c_slave)
echo "$out"
echo "$out" | grep -q "^Simulation passed$" && exit 0 || exit 1

// File: src.f
+incdir+include
logic/i2c_slave_pkg.sv
logic/i2c_line_filter.sv
logic/i2c_target_fsm.sv
logic/pec_crc8.sv
logic/reg_bus_bridge.sv
logic/i2c_slave_top.sv
bench/tb_i2c_slave.sv
